// ==== list.f ====
+incdir+verification
logic/aes_key_pkg.sv
logic/sbox_word.sv
logic/key_word_step.sv
logic/key_expander.sv
logic/round_key_arbiter.sv
logic/round_key_store.sv
logic/apb_key_regs.sv
logic/aes_key_schedule_top.sv
verification/tb_aes_key_schedule.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the key schedule testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_aes_key_schedule -f list.f

out=$(./obj_dir/Vtb_aes_key_schedule)
echo "$out"

# Pass only when the testbench reported a pass.
echo "$out" | grep -q "^=== PASS ===$"

// ==== verification/tb_key_model.svh ====
`ifndef TB_KEY_MODEL_SVH
`define TB_KEY_MODEL_SVH

// ------------------------------------------------------------
// Reference model of AES key expansion.
// ------------------------------------------------------------

logic [7:0] sbox_tab [256];
key_word_t  model_w  [MAX_TOTAL_WORDS];

// Shift-and-add product, then fold back by x^8+x^4+x^3+x+1.
function automatic logic [7:0] gf_times(input logic [7:0] a, input logic [7:0] b);
    logic [15:0] prod;
    prod = '0;
    for (int i = 0; i < 8; i++)
    begin
        if (b[i])
            prod = prod ^ (16'(a) << i);
    end
    for (int i = 15; i >= 8; i--)
    begin
        if (prod[i])
            prod = prod ^ (16'h011b << (i - 8));
    end
    return prod[7:0];
endfunction

// Inverse by exhaustive search. Zero keeps zero.
function automatic logic [7:0] sbox_search(input logic [7:0] a);
    logic [7:0] inv;
    logic [7:0] s;
    inv = 8'h00;
    for (int c = 1; c < 256; c++)
    begin
        if (gf_times(a, 8'(c)) == 8'h01)
            inv = 8'(c);
    end
    // Affine step, bit by bit.
    for (int i = 0; i < 8; i++)
    begin
        s[i] = inv[i] ^ inv[(i + 4) % 8] ^ inv[(i + 5) % 8]
             ^ inv[(i + 6) % 8] ^ inv[(i + 7) % 8];
    end
    return s ^ 8'h63;
endfunction

function automatic key_word_t sub_word(input key_word_t w);
    return {sbox_tab[w[31:24]], sbox_tab[w[23:16]], sbox_tab[w[15:8]], sbox_tab[w[7:0]]};
endfunction

// Full schedule of cur_key into model_w.
function automatic void expand_model();
    key_word_t  t;
    logic [7:0] rc;
    rc = 8'h01;
    for (int i = 0; i < TOTAL; i++)
    begin
        if (i < NK)
            model_w[i] = cur_key[i];
        else
        begin
            t = model_w[i - 1];
            if (i % NK == 0)
            begin
                t  = sub_word({t[23:0], t[31:24]}) ^ {rc, 24'h000000};
                rc = gf_times(rc, 8'h02);
            end
            else if (NK > 6 && i % NK == 4)
                t = sub_word(t);
            model_w[i] = model_w[i - NK] ^ t;
        end
    end
endfunction

`endif

// ==== verification/tb_aes_key_schedule.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_aes_key_schedule;
    import aes_key_pkg::*;

    localparam int NK          = 8;
    localparam int TOTAL       = 4 * (NK + 6) + 4;
    localparam int APB_TIMEOUT = 50;
    localparam int DONE_POLLS  = 100;
    // Idle cycles before the status read that follows an ignored start.
    localparam int RESTART_GAP = TOTAL - 5;

    logic      i_clock;
    logic      i_arst_n;
    logic      i_psel;
    logic      i_penable;
    logic      i_pwrite;
    apb_addr_t i_paddr;
    key_word_t i_pwdata;
    key_word_t o_prdata;
    logic      o_pready;
    logic      o_pslverr;

    key_word_t cur_key [MAX_KEY_WORDS];
    int        errors;
    int        timeouts;

    `include "tb_key_model.svh"

    aes_key_schedule_top #(.N_KEY_WORDS(NK)) dut0
    (
        .i_clock   (i_clock),
        .i_arst_n  (i_arst_n),
        .i_psel    (i_psel),
        .i_penable (i_penable),
        .i_pwrite  (i_pwrite),
        .i_paddr   (i_paddr),
        .i_pwdata  (i_pwdata),
        .o_prdata  (o_prdata),
        .o_pready  (o_pready),
        .o_pslverr (o_pslverr)
    );

    // 4 ns clock.
    initial
    begin
        i_clock = 1'b0;
        forever #2 i_clock = ~i_clock;
    end

    task automatic check_equal(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (expected == actual)
        else
        begin
            errors++;
            $display("FAILED %s expected %08h actual %08h", name, expected, actual);
        end
    endtask

    // ------------------------------------------------------------
    // APB master.
    // ------------------------------------------------------------
    task automatic apb_xfer(input logic write, input apb_addr_t addr, input key_word_t wdata,
                            output key_word_t rdata, output logic slverr);
        int waited;
        @(posedge i_clock);
        i_psel    <= 1'b1;
        i_penable <= 1'b0;
        i_pwrite  <= write;
        i_paddr   <= addr;
        i_pwdata  <= wdata;
        @(posedge i_clock);
        i_penable <= 1'b1;
        // Outputs settle by the falling edge.
        waited = 0;
        @(negedge i_clock);
        while (!o_pready && waited < APB_TIMEOUT)
        begin
            @(negedge i_clock);
            waited++;
        end
        if (!o_pready)
        begin
            timeouts++;
            $display("ERROR: no pready within %0d cycles at address %03h", APB_TIMEOUT, addr);
        end
        rdata  = o_prdata;
        slverr = o_pslverr;
        @(posedge i_clock);
        i_psel    <= 1'b0;
        i_penable <= 1'b0;
    endtask

    task automatic apb_read(input apb_addr_t addr, output key_word_t rdata,
                            output logic slverr);
        apb_xfer(1'b0, addr, '0, rdata, slverr);
    endtask

    task automatic apb_write(input apb_addr_t addr, input key_word_t wdata,
                             output logic slverr);
        key_word_t unused;
        apb_xfer(1'b1, addr, wdata, unused, slverr);
    endtask

    // New key into the model and the key registers.
    task automatic load_random_key();
        logic err;
        for (int k = 0; k < NK; k++)
        begin
            cur_key[k] = $urandom();
            apb_write(apb_addr_t'(KEY_BASE + 4 * k), cur_key[k], err);
        end
    endtask

    task automatic start_expansion();
        logic err;
        apb_write(CTRL_ADDR, 32'h1, err);
    endtask

    // Poll STATUS until done.
    task automatic wait_done(input string name);
        key_word_t status;
        logic      err;
        int        polls;
        polls = 0;
        apb_read(STATUS_ADDR, status, err);
        while (!status[1] && polls < DONE_POLLS)
        begin
            apb_read(STATUS_ADDR, status, err);
            polls++;
        end
        if (!status[1])
        begin
            timeouts++;
            $display("ERROR: %s expansion not done after %0d status polls", name, DONE_POLLS);
        end
        else
            check_equal({name, "_status"}, 32'h2, status);
    endtask

    // Whole store against the model.
    task automatic verify_store(input string name);
        key_word_t rdata;
        logic      err;
        expand_model();
        for (int i = 0; i < TOTAL; i++)
        begin
            apb_read(apb_addr_t'(RK_BASE + 4 * i), rdata, err);
            check_equal($sformatf("%s_rk%0d", name, i), model_w[i], rdata);
            check_equal($sformatf("%s_rk%0d_err", name, i), 32'h0, 32'(err));
        end
    endtask

    // ------------------------------------------------------------
    // Test sequence.
    // ------------------------------------------------------------
    initial
    begin
        key_word_t rdata;
        logic      err;
        errors    = 0;
        timeouts  = 0;
        i_arst_n  = 1'b0;
        i_psel    = 1'b0;
        i_penable = 1'b0;
        i_pwrite  = 1'b0;
        i_paddr   = '0;
        i_pwdata  = '0;
        void'($urandom(42));
        for (int i = 0; i < 256; i++)
        begin
            sbox_tab[i] = sbox_search(8'(i));
        end
        repeat (5) @(posedge i_clock);
        i_arst_n <= 1'b1;

        // Idle after reset.
        apb_read(STATUS_ADDR, rdata, err);
        check_equal("reset_status", 32'h0, rdata);

        // Single expansion, then five back to back.
        load_random_key();
        start_expansion();
        wait_done("single");
        verify_store("single");
        for (int r = 0; r < 5; r++)
        begin
            load_random_key();
            start_expansion();
            wait_done($sformatf("b2b%0d", r));
            verify_store($sformatf("b2b%0d", r));
        end

        // Store reads race the expander for the port.
        load_random_key();
        start_expansion();
        for (int n = 0; n < 16; n++)
        begin
            apb_read(apb_addr_t'(RK_BASE + 4 * ($urandom() % TOTAL)), rdata, err);
            check_equal($sformatf("contend%0d_err", n), 32'h0, 32'(err));
        end
        wait_done("contend");
        verify_store("contend");

        // Second start while busy is dropped.
        load_random_key();
        start_expansion();
        apb_read(STATUS_ADDR, rdata, err);
        check_equal("restart_busy", 32'h1, rdata);
        start_expansion();
        // A restart would keep busy high past the fixed expansion length.
        repeat (RESTART_GAP) @(posedge i_clock);
        apb_read(STATUS_ADDR, rdata, err);
        check_equal("restart_done", 32'h2, rdata);
        wait_done("restart");
        verify_store("restart");

        // Error responses.
        apb_read(apb_addr_t'(RK_BASE + 4 * TOTAL), rdata, err);
        check_equal("rk_range_err", 32'h1, 32'(err));
        apb_write(STATUS_ADDR, 32'h3, err);
        check_equal("status_write_err", 32'h1, 32'(err));
        // Holes in the map read zero.
        apb_read(9'h028, rdata, err);
        check_equal("unmapped_028", 32'h0, rdata);
        check_equal("unmapped_028_err", 32'h0, 32'(err));
        apb_read(9'h0fc, rdata, err);
        check_equal("unmapped_0fc", 32'h0, rdata);
        check_equal("unmapped_0fc_err", 32'h0, 32'(err));

        $display("Summary: %0d value errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

// ==== logic/aes_key_schedule_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module aes_key_schedule_top
#(
    parameter int N_KEY_WORDS = 8
)
(
    input  wire                         i_clock,
    input  wire                         i_arst_n,
    input  wire                         i_psel,
    input  wire                         i_penable,
    input  wire                         i_pwrite,
    input  wire aes_key_pkg::apb_addr_t i_paddr,
    input  wire aes_key_pkg::key_word_t i_pwdata,
    output aes_key_pkg::key_word_t      o_prdata,
    output logic                        o_pready,
    output logic                        o_pslverr
);
    import aes_key_pkg::*;

    // APB to expander control.
    logic                         start;
    logic [32*MAX_KEY_WORDS-1:0]  key_flat;
    logic                         busy;
    logic                         done;

    // Requester and store port nets.
    logic      exp_req;
    logic      exp_we;
    word_idx_t exp_addr;
    key_word_t exp_wdata;
    logic      exp_gnt;
    logic      apb_req;
    word_idx_t apb_addr;
    logic      apb_gnt;
    logic      mem_en;
    logic      mem_we;
    word_idx_t mem_addr;
    key_word_t mem_wdata;
    key_word_t mem_rdata;

    apb_key_regs #(.N_KEY_WORDS(N_KEY_WORDS)) u_apb
    (
        .i_clock         (i_clock),
        .i_arst_n        (i_arst_n),
        .i_psel          (i_psel),
        .i_penable       (i_penable),
        .i_pwrite        (i_pwrite),
        .i_paddr         (i_paddr),
        .i_pwdata        (i_pwdata),
        .o_prdata        (o_prdata),
        .o_pready        (o_pready),
        .o_pslverr       (o_pslverr),
        .o_start         (start),
        .o_key_word_flat (key_flat),
        .i_busy          (busy),
        .i_done          (done),
        .o_req           (apb_req),
        .o_addr          (apb_addr),
        .i_gnt           (apb_gnt),
        .i_rdata         (mem_rdata)
    );

    key_expander #(.N_KEY_WORDS(N_KEY_WORDS)) u_expander
    (
        .i_clock         (i_clock),
        .i_arst_n        (i_arst_n),
        .i_start         (start),
        .i_key_word_flat (key_flat),
        .o_busy          (busy),
        .o_done          (done),
        .o_req           (exp_req),
        .o_we            (exp_we),
        .o_addr          (exp_addr),
        .o_wdata         (exp_wdata),
        .i_gnt           (exp_gnt)
    );

    round_key_arbiter u_arbiter
    (
        .i_clock     (i_clock),
        .i_arst_n    (i_arst_n),
        .i_exp_req   (exp_req),
        .i_exp_we    (exp_we),
        .i_exp_addr  (exp_addr),
        .i_exp_wdata (exp_wdata),
        .i_apb_req   (apb_req),
        .i_apb_addr  (apb_addr),
        .o_exp_gnt   (exp_gnt),
        .o_apb_gnt   (apb_gnt),
        .o_mem_en    (mem_en),
        .o_mem_we    (mem_we),
        .o_mem_addr  (mem_addr),
        .o_mem_wdata (mem_wdata)
    );

    round_key_store u_store
    (
        .i_clock (i_clock),
        .i_en    (mem_en),
        .i_we    (mem_we),
        .i_addr  (mem_addr),
        .i_wdata (mem_wdata),
        .o_rdata (mem_rdata)
    );

endmodule

`default_nettype wire

// ==== logic/apb_key_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module apb_key_regs
#(
    parameter int N_KEY_WORDS = 8
)
(
    input  wire                                      i_clock,
    input  wire                                      i_arst_n,
    input  wire                                      i_psel,
    input  wire                                      i_penable,
    input  wire                                      i_pwrite,
    input  wire aes_key_pkg::apb_addr_t              i_paddr,
    input  wire aes_key_pkg::key_word_t              i_pwdata,
    output aes_key_pkg::key_word_t                   o_prdata,
    output logic                                     o_pready,
    output logic                                     o_pslverr,
    output logic                                     o_start,
    output logic [32*aes_key_pkg::MAX_KEY_WORDS-1:0] o_key_word_flat,
    input  wire                                      i_busy,
    input  wire                                      i_done,
    output logic                                     o_req,
    output aes_key_pkg::word_idx_t                   o_addr,
    input  wire                                      i_gnt,
    input  wire aes_key_pkg::key_word_t              i_rdata
);
    import aes_key_pkg::*;

    localparam int N_ROUNDS = N_KEY_WORDS + 6;
    localparam int N_TOTAL  = 4 * N_ROUNDS + 4;

    typedef enum logic [1:0] {RD_IDLE, RD_WAIT_GNT, RD_WAIT_DATA} rd_state_t;

    rd_state_t rd_state;
    key_word_t key_reg [MAX_KEY_WORDS];
    logic      access;
    logic      is_key;
    logic      is_ctrl;
    logic      is_status;
    logic      is_rk;
    logic      rk_in_range;
    logic      rk_read;

    // ------------------------------------------------------------
    // Address decode.
    // ------------------------------------------------------------
    assign access      = i_psel & i_penable;
    assign is_key      = (i_paddr[8:5] == KEY_BASE[8:5]);
    assign is_ctrl     = (i_paddr == CTRL_ADDR);
    assign is_status   = (i_paddr == STATUS_ADDR);
    assign is_rk       = (i_paddr[8] == RK_BASE[8]);
    // Word index of a round-key read, held stable by APB.
    assign o_addr      = i_paddr[7:2];
    assign rk_in_range = (o_addr < N_TOTAL);
    assign rk_read     = access & ~i_pwrite & is_rk & rk_in_range;

    // Store request only while waiting for the grant.
    assign o_req = (rd_state == RD_WAIT_GNT);

    // Registers answer at once. Round-key reads wait for data.
    assign o_pready  = access & (~rk_read | (rd_state == RD_WAIT_DATA));
    assign o_pslverr = access & ((is_rk & (i_pwrite | ~rk_in_range)) | (i_pwrite & is_status));

    // Key and control read as zero. So does any unmapped address.
    always_comb
    begin
        o_prdata = '0;
        if (rd_state == RD_WAIT_DATA)
            o_prdata = i_rdata;
        else if (is_status)
            o_prdata = {30'b0, i_done, i_busy};
    end

    // ------------------------------------------------------------
    // Start strobe and round-key read FSM.
    // ------------------------------------------------------------
    always_ff @(posedge i_clock or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            rd_state <= RD_IDLE;
            o_start  <= 1'b0;
        end
        else
        begin
            o_start <= access & i_pwrite & is_ctrl & i_pwdata[0];
            case (rd_state)
                RD_IDLE:      if (rk_read) rd_state <= RD_WAIT_GNT;
                RD_WAIT_GNT:  if (i_gnt) rd_state <= RD_WAIT_DATA;
                RD_WAIT_DATA: rd_state <= RD_IDLE;
                default:      rd_state <= RD_IDLE;
            endcase
        end
    end

    // Write-only key words.
    always_ff @(posedge i_clock)
    begin
        if (access && i_pwrite && is_key)
            key_reg[i_paddr[4:2]] <= i_pwdata;
    end

    for (genvar k = 0; k < MAX_KEY_WORDS; k++)
    begin : gen_flat
        assign o_key_word_flat[32*k +: 32] = key_reg[k];
    end

    // The store is only touched inside an APB access.
    a_req_in_access: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        o_req |-> (i_psel && i_penable));

endmodule

`default_nettype wire

// ==== logic/round_key_store.sv ====
`timescale 1ns/1ps
`default_nettype none

module round_key_store
(
    input  wire                         i_clock,
    input  wire                         i_en,
    input  wire                         i_we,
    input  wire aes_key_pkg::word_idx_t i_addr,
    input  wire aes_key_pkg::key_word_t i_wdata,
    output aes_key_pkg::key_word_t      o_rdata
);
    import aes_key_pkg::*;

    // One word per expanded key slot.
    key_word_t mem [MAX_TOTAL_WORDS];

    // Write on the grant edge, read data one cycle later.
    always_ff @(posedge i_clock)
    begin
        if (i_en)
        begin
            if (i_we)
                mem[i_addr] <= i_wdata;
            else
                o_rdata <= mem[i_addr];
        end
    end

endmodule

`default_nettype wire

// ==== logic/round_key_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module round_key_arbiter
(
    input  wire                         i_clock,
    input  wire                         i_arst_n,
    input  wire                         i_exp_req,
    input  wire                         i_exp_we,
    input  wire aes_key_pkg::word_idx_t i_exp_addr,
    input  wire aes_key_pkg::key_word_t i_exp_wdata,
    input  wire                         i_apb_req,
    input  wire aes_key_pkg::word_idx_t i_apb_addr,
    output logic                        o_exp_gnt,
    output logic                        o_apb_gnt,
    output logic                        o_mem_en,
    output logic                        o_mem_we,
    output aes_key_pkg::word_idx_t      o_mem_addr,
    output aes_key_pkg::key_word_t      o_mem_wdata
);

    // Set when APB won the last contested or single grant.
    logic last_apb;

    // Round robin. On a tie the side that did not win last goes.
    assign o_exp_gnt = i_exp_req & (~i_apb_req | last_apb);
    assign o_apb_gnt = i_apb_req & (~i_exp_req | ~last_apb);

    // Granted side drives the store port.
    assign o_mem_en    = o_exp_gnt | o_apb_gnt;
    assign o_mem_we    = o_exp_gnt & i_exp_we;
    assign o_mem_addr  = o_apb_gnt ? i_apb_addr : i_exp_addr;
    assign o_mem_wdata = i_exp_wdata;  // APB side only reads.

    // Reset value favours the expander first.
    always_ff @(posedge i_clock or negedge i_arst_n)
    begin
        if (!i_arst_n)
            last_apb <= 1'b1;
        else if (o_exp_gnt)
            last_apb <= 1'b0;
        else if (o_apb_gnt)
            last_apb <= 1'b1;
    end

    a_one_grant: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        $onehot0({o_exp_gnt, o_apb_gnt}));

endmodule

`default_nettype wire

// ==== logic/key_expander.sv ====
`timescale 1ns/1ps
`default_nettype none

module key_expander
#(
    parameter int N_KEY_WORDS = 8
)
(
    input  wire                                      i_clock,
    input  wire                                      i_arst_n,
    input  wire                                      i_start,
    input  wire [32*aes_key_pkg::MAX_KEY_WORDS-1:0]  i_key_word_flat,
    output logic                                     o_busy,
    output logic                                     o_done,
    output logic                                     o_req,
    output logic                                     o_we,
    output aes_key_pkg::word_idx_t                   o_addr,
    output aes_key_pkg::key_word_t                   o_wdata,
    input  wire                                      i_gnt
);
    import aes_key_pkg::*;

    localparam int        N_ROUNDS  = N_KEY_WORDS + 6;
    localparam int        N_TOTAL   = 4 * N_ROUNDS + 4;
    localparam word_idx_t LAST_KEY  = word_idx_t'(N_KEY_WORDS - 1);
    localparam word_idx_t LAST_WORD = word_idx_t'(N_TOTAL - 1);

    typedef enum logic [1:0] {ST_IDLE, ST_LOAD, ST_EXPAND} exp_state_t;

    exp_state_t state;
    word_idx_t  idx;
    key_word_t  window [N_KEY_WORDS];  // [0] oldest, [N-1] newest.
    key_word_t  step_word;

    // Next word from w[i-1] and w[i-NK].
    key_word_step #(.N_KEY_WORDS(N_KEY_WORDS)) u_step
    (
        .i_word_prev    (window[N_KEY_WORDS-1]),
        .i_word_back_nk (window[0]),
        .i_index        (idx),
        .o_word         (step_word)
    );

    // Every active cycle is a write request.
    assign o_busy  = (state != ST_IDLE);
    assign o_req   = o_busy;
    assign o_we    = o_busy;
    assign o_addr  = idx;
    // Key registers are sampled as each initial word goes out.
    assign o_wdata = (state == ST_LOAD) ? i_key_word_flat[32*idx[2:0] +: 32] : step_word;

    // ------------------------------------------------------------
    // Sequencer. Advances only on a grant.
    // ------------------------------------------------------------
    always_ff @(posedge i_clock or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            state  <= ST_IDLE;
            idx    <= '0;
            o_done <= 1'b0;
        end
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    if (i_start)
                    begin
                        state  <= ST_LOAD;
                        idx    <= '0;
                        o_done <= 1'b0;
                    end
                end
                ST_LOAD:
                begin
                    if (i_gnt)
                    begin
                        idx <= idx + 1'b1;
                        if (idx == LAST_KEY)
                            state <= ST_EXPAND;
                    end
                end
                ST_EXPAND:
                begin
                    if (i_gnt)
                    begin
                        idx <= idx + 1'b1;
                        if (idx == LAST_WORD)
                        begin
                            state  <= ST_IDLE;
                            o_done <= 1'b1;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Shift window. Stalls with the index.
    always_ff @(posedge i_clock)
    begin
        if (o_req && i_gnt)
        begin
            for (int i = 0; i < N_KEY_WORDS - 1; i++)
            begin
                window[i] <= window[i + 1];
            end
            window[N_KEY_WORDS-1] <= o_wdata;
        end
    end

    // No request ever targets a slot past the schedule.
    a_addr_in_range: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        o_req |-> (o_addr < N_TOTAL));

endmodule

`default_nettype wire

// ==== logic/key_word_step.sv ====
`timescale 1ns/1ps
`default_nettype none

module key_word_step
#(
    parameter int N_KEY_WORDS = 8
)
(
    input  wire aes_key_pkg::key_word_t i_word_prev,
    input  wire aes_key_pkg::key_word_t i_word_back_nk,
    input  wire aes_key_pkg::word_idx_t i_index,
    output aes_key_pkg::key_word_t      o_word
);
    import aes_key_pkg::*;

    key_word_t sub_word;
    key_word_t rot_word;
    key_word_t temp_word;
    word_idx_t phase;
    word_idx_t round;

    // Position inside the key period and round number.
    assign phase = word_idx_t'(i_index % N_KEY_WORDS);
    assign round = word_idx_t'(i_index / N_KEY_WORDS);

    // SubWord of the previous word.
    sbox_word u_sbox
    (
        .i_word (i_word_prev),
        .o_word (sub_word)
    );

    // RotWord after SubWord gives the same bytes. Rcon on the top byte.
    // Round never exceeds 10 here, so 4 bits are enough.
    assign rot_word = {sub_word[23:0], sub_word[31:24]}
                    ^ {rcon_byte(round[3:0]), 24'h000000};

    // ------------------------------------------------------------
    // Transform select.
    // ------------------------------------------------------------
    always_comb
    begin
        if (phase == '0)
            temp_word = rot_word;
        else if ((N_KEY_WORDS == 8) && (phase == word_idx_t'(4)))
            temp_word = sub_word;  // AES-256 midpoint.
        else
            temp_word = i_word_prev;
    end

    // Fold in the word one key period back.
    assign o_word = temp_word ^ i_word_back_nk;

endmodule

`default_nettype wire

// ==== logic/sbox_word.sv ====
`timescale 1ns/1ps
`default_nettype none

module sbox_word
(
    input  wire aes_key_pkg::key_word_t i_word,
    output aes_key_pkg::key_word_t      o_word
);

    // GF(2^8) product, reduction polynomial 0x11b.
    function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] p;
        logic [7:0] x;
        p = 8'h00;
        x = a;
        for (int i = 0; i < 8; i++)
        begin
            if (b[i])
                p = p ^ x;
            // xtime step.
            x = {x[6:0], 1'b0} ^ (x[7] ? 8'h1b : 8'h00);
        end
        return p;
    endfunction

    // Inverse as a^254. Zero maps to zero.
    function automatic logic [7:0] gf_inv(input logic [7:0] a);
        logic [7:0] sq;
        logic [7:0] acc;
        sq  = a;
        acc = 8'h01;
        // Collect a^2 * a^4 * ... * a^128.
        for (int i = 1; i < 8; i++)
        begin
            sq  = gf_mul(sq, sq);
            acc = gf_mul(acc, sq);
        end
        return acc;
    endfunction

    // Affine map over GF(2), constant 0x63.
    function automatic logic [7:0] affine(input logic [7:0] b);
        return b ^ {b[6:0], b[7]} ^ {b[5:0], b[7:6]}
                 ^ {b[4:0], b[7:5]} ^ {b[3:0], b[7:4]} ^ 8'h63;
    endfunction

    // One S-box per byte.
    for (genvar g = 0; g < 4; g++)
    begin : gen_byte
        assign o_word[8*g +: 8] = affine(gf_inv(i_word[8*g +: 8]));
    end

endmodule

`default_nettype wire

// ==== logic/aes_key_pkg.sv ====
`default_nettype none

package aes_key_pkg;

    // Word, index and bus address types.
    typedef logic [31:0] key_word_t;
    typedef logic [5:0]  word_idx_t;
    typedef logic [8:0]  apb_addr_t;

    // Size limits, set by AES-256.
    localparam int MAX_KEY_WORDS   = 8;
    localparam int MAX_TOTAL_WORDS = 60;

    // ------------------------------------------------------------
    // APB byte address map.
    // ------------------------------------------------------------
    localparam apb_addr_t KEY_BASE    = 9'h000;
    localparam apb_addr_t CTRL_ADDR   = 9'h020;
    localparam apb_addr_t STATUS_ADDR = 9'h024;
    localparam apb_addr_t RK_BASE     = 9'h100;

    // Round constant, first byte of Rcon[round].
    function automatic logic [7:0] rcon_byte(input logic [3:0] round);
        case (round)
            4'd1:    rcon_byte = 8'h01;
            4'd2:    rcon_byte = 8'h02;
            4'd3:    rcon_byte = 8'h04;
            4'd4:    rcon_byte = 8'h08;
            4'd5:    rcon_byte = 8'h10;
            4'd6:    rcon_byte = 8'h20;
            4'd7:    rcon_byte = 8'h40;
            4'd8:    rcon_byte = 8'h80;
            4'd9:    rcon_byte = 8'h1b;
            4'd10:   rcon_byte = 8'h36;
            default: rcon_byte = 8'h00;
        endcase
    endfunction

endpackage

`default_nettype wire
